/* Bender.yml */
package:
  name: map_table

sources:
  - logic/rename_cfg_pkg.sv
  - logic/rename_types_pkg.sv
  - logic/map_table_ifs.sv
  - logic/map_update_ctrl.sv
  - logic/cdb_tag_matcher.sv
  - logic/map_table_store.sv
  - logic/operand_lookup.sv
  - logic/map_table.sv
  - target: test
    files:
      - tb/map_table_props.sv
      - tb/map_table_tb.sv

/* logic/cdb_tag_matcher.sv */
module cdb_tag_matcher (
    input  logic [rename_cfg_pkg::NUM_LANES-1:0]                       cdb_valid,
    input  rename_types_pkg::rob_tag_t [rename_cfg_pkg::NUM_LANES-1:0] cdb_tag,
    map_state_if.reader                                                state,
    output logic [rename_cfg_pkg::NUM_MAPPED_REGS-1:0]                 cdb_hit
);
    import rename_cfg_pkg::*;

    // One comparator per entry and broadcast lane
    logic [NUM_MAPPED_REGS-1:0][NUM_LANES-1:0] lane_match;

    always_comb begin
        for (int k = 0; k < NUM_MAPPED_REGS; k++) begin
            for (int l = 0; l < NUM_LANES; l++) begin
                lane_match[k][l] = cdb_valid[l] &&
                                   (state.entry_tag[k] == cdb_tag[l]);
            end
        end
    end

    // Stale tags in unmapped entries must not match
    always_comb begin
        for (int k = 0; k < NUM_MAPPED_REGS; k++) begin
            cdb_hit[k] = state.entry_mapped[k] & (|lane_match[k]);
        end
    end

endmodule

/* logic/map_table.sv */
module map_table (
    input  logic                                                        clock,
    input  logic                                                        rst_n,
    input  logic                                                        squash,
    // Rename lanes
    input  logic [rename_cfg_pkg::NUM_LANES-1:0]                        rename_valid,
    input  rename_types_pkg::arch_reg_t [rename_cfg_pkg::NUM_LANES-1:0] rename_reg,
    input  rename_types_pkg::rob_tag_t  [rename_cfg_pkg::NUM_LANES-1:0] rename_tag,
    // CDB broadcasts
    input  logic [rename_cfg_pkg::NUM_LANES-1:0]                        cdb_valid,
    input  rename_types_pkg::rob_tag_t  [rename_cfg_pkg::NUM_LANES-1:0] cdb_tag,
    // Dispatch lookups
    input  logic [rename_cfg_pkg::NUM_LANES-1:0]                        lookup_valid,
    input  logic [rename_cfg_pkg::NUM_LANES-1:0]                        lookup_use_rs1,
    input  logic [rename_cfg_pkg::NUM_LANES-1:0]                        lookup_use_rs2,
    input  rename_types_pkg::arch_reg_t [rename_cfg_pkg::NUM_LANES-1:0] lookup_rs1,
    input  rename_types_pkg::arch_reg_t [rename_cfg_pkg::NUM_LANES-1:0] lookup_rs2,
    // Operand mapping to the reservation station
    output rename_types_pkg::rob_tag_t  [rename_cfg_pkg::NUM_LANES-1:0] src1_tag,
    output logic [rename_cfg_pkg::NUM_LANES-1:0]                        src1_ready,
    output logic [rename_cfg_pkg::NUM_LANES-1:0]                        src1_mapped,
    output rename_types_pkg::rob_tag_t  [rename_cfg_pkg::NUM_LANES-1:0] src2_tag,
    output logic [rename_cfg_pkg::NUM_LANES-1:0]                        src2_ready,
    output logic [rename_cfg_pkg::NUM_LANES-1:0]                        src2_mapped
);
    import rename_cfg_pkg::*;
    import rename_types_pkg::*;

    map_state_if state_if ();
    map_write_if write_if ();

    logic [NUM_MAPPED_REGS-1:0] cdb_hit;       // Entries completed this cycle
    operand_map_t               lane_src1 [NUM_LANES];
    operand_map_t               lane_src2 [NUM_LANES];

    cdb_tag_matcher i_cdb_tag_matcher (
        .cdb_valid (cdb_valid),
        .cdb_tag   (cdb_tag),
        .state     (state_if),
        .cdb_hit   (cdb_hit)
    );

    map_update_ctrl i_map_update_ctrl (
        .rst_n        (rst_n),
        .squash       (squash),
        .rename_valid (rename_valid),
        .rename_reg   (rename_reg),
        .rename_tag   (rename_tag),
        .cdb_hit      (cdb_hit),
        .state        (state_if),
        .write        (write_if)
    );

    map_table_store i_map_table_store (
        .clock (clock),
        .write (write_if),
        .state (state_if)
    );

    for (genvar l = 0; l < NUM_LANES; l++) begin : g_lookup
        operand_lookup i_operand_lookup (
            .lookup_valid (lookup_valid[l]),
            .use_rs1      (lookup_use_rs1[l]),
            .use_rs2      (lookup_use_rs2[l]),
            .rs1          (lookup_rs1[l]),
            .rs2          (lookup_rs2[l]),
            .state        (state_if),
            .src1         (lane_src1[l]),
            .src2         (lane_src2[l])
        );

        // Flatten lane results onto the plain ports
        assign src1_tag[l]    = lane_src1[l].tag;
        assign src1_ready[l]  = lane_src1[l].ready;
        assign src1_mapped[l] = lane_src1[l].mapped;
        assign src2_tag[l]    = lane_src2[l].tag;
        assign src2_ready[l]  = lane_src2[l].ready;
        assign src2_mapped[l] = lane_src2[l].mapped;
    end

endmodule

/* logic/map_table_ifs.sv */
// Table contents as registered, one field per column
interface map_state_if;
    import rename_cfg_pkg::*;
    import rename_types_pkg::*;

    rob_tag_t [NUM_MAPPED_REGS-1:0] entry_tag;      // Tag per entry
    logic     [NUM_MAPPED_REGS-1:0] entry_ready;    // Ready bit per entry
    logic     [NUM_MAPPED_REGS-1:0] entry_mapped;   // Mapped bit per entry

    modport store (
        output entry_tag,
        output entry_ready,
        output entry_mapped
    );

    modport reader (
        input entry_tag,
        input entry_ready,
        input entry_mapped
    );

endinterface

// Next-state command from the update control to the register store
interface map_write_if;
    import rename_cfg_pkg::*;
    import rename_types_pkg::*;

    logic     [NUM_MAPPED_REGS-1:0] write_en;       // Load this entry
    rob_tag_t [NUM_MAPPED_REGS-1:0] write_tag;
    logic     [NUM_MAPPED_REGS-1:0] write_ready;
    logic     [NUM_MAPPED_REGS-1:0] write_mapped;
    logic                           clear;          // Wipe whole table

    modport ctrl (
        output write_en,
        output write_tag,
        output write_ready,
        output write_mapped,
        output clear
    );

    modport store (
        input write_en,
        input write_tag,
        input write_ready,
        input write_mapped,
        input clear
    );

endinterface

/* logic/map_table_store.sv */
module map_table_store (
    input  logic        clock,
    map_write_if.store  write,
    map_state_if.store  state
);
    import rename_cfg_pkg::*;
    import rename_types_pkg::*;

    map_entry_t entry_q [NUM_MAPPED_REGS];    // Table rows

    always_ff @(posedge clock) begin
        if (write.clear) begin
            for (int k = 0; k < NUM_MAPPED_REGS; k++) begin
                entry_q[k] <= '0;              // Every register unrenamed
            end
        end else begin
            for (int k = 0; k < NUM_MAPPED_REGS; k++) begin
                if (write.write_en[k]) begin
                    entry_q[k] <= '{
                        tag:    write.write_tag[k],
                        ready:  write.write_ready[k],
                        mapped: write.write_mapped[k]
                    };
                end
            end
        end
    end

    // Present rows column-wise to the readers
    always_comb begin
        for (int k = 0; k < NUM_MAPPED_REGS; k++) begin
            state.entry_tag[k]    = entry_q[k].tag;
            state.entry_ready[k]  = entry_q[k].ready;
            state.entry_mapped[k] = entry_q[k].mapped;
        end
    end

endmodule

/* logic/map_update_ctrl.sv */
module map_update_ctrl (
    input  logic                                                    rst_n,
    input  logic                                                    squash,
    input  logic [rename_cfg_pkg::NUM_LANES-1:0]                    rename_valid,
    input  rename_types_pkg::arch_reg_t [rename_cfg_pkg::NUM_LANES-1:0] rename_reg,
    input  rename_types_pkg::rob_tag_t  [rename_cfg_pkg::NUM_LANES-1:0] rename_tag,
    input  logic [rename_cfg_pkg::NUM_MAPPED_REGS-1:0]              cdb_hit,
    map_state_if.reader                                             state,
    map_write_if.ctrl                                               write
);
    import rename_cfg_pkg::*;
    import rename_types_pkg::*;

    // One-hot entry select for each rename lane
    logic [NUM_LANES-1:0][NUM_MAPPED_REGS-1:0] lane_sel;

    // Squash restores the same empty table as reset
    assign write.clear = squash | ~rst_n;

    // Decode destination registers into entry selects
    // Entry k holds register k+1, so x0 never matches any entry
    always_comb begin
        for (int l = 0; l < NUM_LANES; l++) begin
            for (int k = 0; k < NUM_MAPPED_REGS; k++) begin
                lane_sel[l][k] = rename_valid[l] &&
                                 (rename_reg[l] == arch_reg_t'(k + 1));
            end
        end
    end

    // Next state per entry
    // The lowest priority is the held state, then a CDB hit raises ready,
    // then renames overwrite in lane order so the highest lane wins
    always_comb begin
        for (int k = 0; k < NUM_MAPPED_REGS; k++) begin
            write.write_en[k]     = cdb_hit[k];                     // Hold unless hit
            write.write_tag[k]    = state.entry_tag[k];
            write.write_ready[k]  = state.entry_ready[k] | cdb_hit[k];
            write.write_mapped[k] = state.entry_mapped[k];

            for (int l = 0; l < NUM_LANES; l++) begin
                if (lane_sel[l][k]) begin
                    write.write_en[k]     = 1'b1;
                    write.write_tag[k]    = rename_tag[l];          // New producer
                    write.write_ready[k]  = 1'b0;                   // Not computed yet
                    write.write_mapped[k] = 1'b1;
                end
            end
        end
    end

    // A rename in the same cycle as a broadcast of the entry's old tag
    // lands in the lane loop after the hit, so the new tag stays not ready.
    // A hit only ever comes from a mapped entry, so raising ready here
    // keeps ready implying mapped.

endmodule

/* logic/operand_lookup.sv */
module operand_lookup (
    input  logic                          lookup_valid,
    input  logic                          use_rs1,
    input  logic                          use_rs2,
    input  rename_types_pkg::arch_reg_t   rs1,
    input  rename_types_pkg::arch_reg_t   rs2,
    map_state_if.reader                   state,
    output rename_types_pkg::operand_map_t src1,
    output rename_types_pkg::operand_map_t src2
);
    import rename_types_pkg::*;

    // Both sources share the same lookup path, index 0 is rs1
    logic         [1:0] src_used;
    arch_reg_t    [1:0] src_reg;
    operand_map_t [1:0] src_res;
    arch_reg_t          entry_idx;

    assign src_used = {use_rs2, use_rs1} & {2{lookup_valid}};
    assign src_reg  = {rs2, rs1};

    // Reads the registered table only, so renames and broadcasts of the
    // current cycle are not visible until after the next edge
    always_comb begin
        for (int s = 0; s < 2; s++) begin
            entry_idx  = src_reg[s] - 1'b1;        // Register k+1 sits in entry k
            src_res[s] = '0;

            if (src_used[s] && (src_reg[s] != '0)) begin
                if (state.entry_mapped[entry_idx]) begin
                    src_res[s] = '{
                        tag:    state.entry_tag[entry_idx],
                        ready:  state.entry_ready[entry_idx],
                        mapped: 1'b1
                    };
                end
            end
        end
    end

    // Unmapped or unused sources read the register file instead
    assign src1 = src_res[0];
    assign src2 = src_res[1];

endmodule

/* logic/rename_cfg_pkg.sv */
package rename_cfg_pkg;

    // Superscalar width
    // Rename, broadcast and dispatch all run this many lanes wide
    localparam int NUM_LANES = 3;

    // Architectural register file
    localparam int ARCH_REG_W = 5;              // x0 to x31
    localparam int NUM_MAPPED_REGS = 31;        // x1 to x31, x0 has no entry

    // Reorder buffer
    localparam int ROB_DEPTH = 32;
    localparam int ROB_TAG_W = $clog2(ROB_DEPTH);   // Tag indexes one ROB slot

    // Entry k of the table belongs to register k+1, so a register index
    // minus one selects its entry. x0 is hardwired to zero and is never
    // renamed, which is why the table has one entry fewer than the
    // register file.

endpackage

/* logic/rename_types_pkg.sv */
package rename_types_pkg;

    // Reorder buffer tag
    typedef logic [rename_cfg_pkg::ROB_TAG_W-1:0] rob_tag_t;

    // Architectural register index
    typedef logic [rename_cfg_pkg::ARCH_REG_W-1:0] arch_reg_t;

    // One row of the map table
    // ready means the producer has broadcast on the CDB, mapped means
    // the register is waiting on an in-flight producer at all
    typedef struct packed {
        rob_tag_t tag;          // Producer ROB slot
        logic     ready;        // Result already on the CDB
        logic     mapped;       // Entry holds a live tag
    } map_entry_t;

    // Result of one source-operand lookup, sent to the reservation station
    // An unmapped source comes back as all zeros and reads the register file
    typedef struct packed {
        rob_tag_t tag;          // Tag to wait on
        logic     ready;        // Value can be read from the ROB
        logic     mapped;       // Source is renamed
    } operand_map_t;

endpackage

/* map_table.f */
logic/rename_cfg_pkg.sv
logic/rename_types_pkg.sv
logic/map_table_ifs.sv
logic/map_update_ctrl.sv
logic/cdb_tag_matcher.sv
logic/map_table_store.sv
logic/operand_lookup.sv
logic/map_table.sv
tb/map_table_props.sv
tb/map_table_tb.sv

/* tb/map_table_props.sv */
module map_table_props (
    input logic                                                        clock,
    input logic                                                        rst_n,
    input logic                                                        squash,
    input logic [rename_cfg_pkg::NUM_LANES-1:0]                        lookup_valid,
    input logic [rename_cfg_pkg::NUM_LANES-1:0]                        lookup_use_rs1,
    input logic [rename_cfg_pkg::NUM_LANES-1:0]                        lookup_use_rs2,
    input rename_types_pkg::arch_reg_t [rename_cfg_pkg::NUM_LANES-1:0] lookup_rs1,
    input rename_types_pkg::arch_reg_t [rename_cfg_pkg::NUM_LANES-1:0] lookup_rs2,
    input logic [rename_cfg_pkg::NUM_LANES-1:0]                        src1_ready,
    input logic [rename_cfg_pkg::NUM_LANES-1:0]                        src1_mapped,
    input logic [rename_cfg_pkg::NUM_LANES-1:0]                        src2_ready,
    input logic [rename_cfg_pkg::NUM_LANES-1:0]                        src2_mapped
);
    import rename_cfg_pkg::*;

    int unsigned fail_count = 0;                // Assertion failures so far

    // Table is empty one cycle after the squash edge
    a_squash_clears: assert property (@(posedge clock) disable iff (!rst_n)
        squash |=> (src1_mapped == '0) && (src2_mapped == '0))
        else begin
            fail_count++;
            $error("Operand mapped in the cycle after a squash");
        end

    for (genvar l = 0; l < NUM_LANES; l++) begin : g_lane
        a_src1_used: assert property (@(posedge clock) disable iff (!rst_n)
            src1_mapped[l] |-> lookup_valid[l] && lookup_use_rs1[l])
            else begin
                fail_count++;
                $error("Lane %0d src1 mapped without a used rs1", l);
            end

        a_src2_used: assert property (@(posedge clock) disable iff (!rst_n)
            src2_mapped[l] |-> lookup_valid[l] && lookup_use_rs2[l])
            else begin
                fail_count++;
                $error("Lane %0d src2 mapped without a used rs2", l);
            end

        a_src1_x0: assert property (@(posedge clock) disable iff (!rst_n)
            (lookup_rs1[l] == '0) |-> !src1_mapped[l])
            else begin
                fail_count++;
                $error("Lane %0d rs1 of x0 came back mapped", l);
            end

        a_src2_x0: assert property (@(posedge clock) disable iff (!rst_n)
            (lookup_rs2[l] == '0) |-> !src2_mapped[l])
            else begin
                fail_count++;
                $error("Lane %0d rs2 of x0 came back mapped", l);
            end

        // Ready only means something on a renamed source
        a_src1_ready: assert property (@(posedge clock) disable iff (!rst_n)
            src1_ready[l] |-> src1_mapped[l])
            else begin
                fail_count++;
                $error("Lane %0d src1 ready while unmapped", l);
            end

        a_src2_ready: assert property (@(posedge clock) disable iff (!rst_n)
            src2_ready[l] |-> src2_mapped[l])
            else begin
                fail_count++;
                $error("Lane %0d src2 ready while unmapped", l);
            end
    end

endmodule

bind map_table map_table_props i_map_table_props (
    .clock          (clock),
    .rst_n          (rst_n),
    .squash         (squash),
    .lookup_valid   (lookup_valid),
    .lookup_use_rs1 (lookup_use_rs1),
    .lookup_use_rs2 (lookup_use_rs2),
    .lookup_rs1     (lookup_rs1),
    .lookup_rs2     (lookup_rs2),
    .src1_ready     (src1_ready),
    .src1_mapped    (src1_mapped),
    .src2_ready     (src2_ready),
    .src2_mapped    (src2_mapped)
);

/* tb/map_table_tb.sv */
module map_table_tb;
    import rename_cfg_pkg::*;
    import rename_types_pkg::*;

    localparam int RESET_CYCLES   = 5;
    localparam int RESET_TEST_LEN = 16;          // Two registers per lane per cycle
    localparam int RENAME_LEN     = 2;
    localparam int BCAST_LEN      = 4;
    localparam int PRIO_LEN       = 2;
    localparam int SQUASH_LEN     = 2;
    localparam int RANDOM_LEN     = 200;
    localparam int TOTAL_CYCLES   = RESET_CYCLES + RESET_TEST_LEN + RENAME_LEN + BCAST_LEN +
                                    PRIO_LEN + SQUASH_LEN + RANDOM_LEN;
    localparam int WATCHDOG_TIME  = TOTAL_CYCLES * 10 * 2;

    logic                      clock;
    logic                      rst_n;
    logic                      squash;
    logic [NUM_LANES-1:0]      rename_valid;
    arch_reg_t [NUM_LANES-1:0] rename_reg;
    rob_tag_t  [NUM_LANES-1:0] rename_tag;
    logic [NUM_LANES-1:0]      cdb_valid;
    rob_tag_t  [NUM_LANES-1:0] cdb_tag;
    logic [NUM_LANES-1:0]      lookup_valid;
    logic [NUM_LANES-1:0]      lookup_use_rs1;
    logic [NUM_LANES-1:0]      lookup_use_rs2;
    arch_reg_t [NUM_LANES-1:0] lookup_rs1;
    arch_reg_t [NUM_LANES-1:0] lookup_rs2;
    rob_tag_t  [NUM_LANES-1:0] src1_tag;
    logic [NUM_LANES-1:0]      src1_ready;
    logic [NUM_LANES-1:0]      src1_mapped;
    rob_tag_t  [NUM_LANES-1:0] src2_tag;
    logic [NUM_LANES-1:0]      src2_ready;
    logic [NUM_LANES-1:0]      src2_mapped;

    map_entry_t  ref_tab [NUM_MAPPED_REGS];     // Expected table contents
    int          error_count;
    int          check_count;

    map_table i_map_table (
        .clock          (clock),
        .rst_n          (rst_n),
        .squash         (squash),
        .rename_valid   (rename_valid),
        .rename_reg     (rename_reg),
        .rename_tag     (rename_tag),
        .cdb_valid      (cdb_valid),
        .cdb_tag        (cdb_tag),
        .lookup_valid   (lookup_valid),
        .lookup_use_rs1 (lookup_use_rs1),
        .lookup_use_rs2 (lookup_use_rs2),
        .lookup_rs1     (lookup_rs1),
        .lookup_rs2     (lookup_rs2),
        .src1_tag       (src1_tag),
        .src1_ready     (src1_ready),
        .src1_mapped    (src1_mapped),
        .src2_tag       (src2_tag),
        .src2_ready     (src2_ready),
        .src2_mapped    (src2_mapped)
    );

    initial begin
        clock = 1'b0;
        forever #5 clock = ~clock;
    end

    task automatic clear_inputs();
        squash         = 1'b0;
        rename_valid   = '0;
        rename_reg     = '0;
        rename_tag     = '0;
        cdb_valid      = '0;
        cdb_tag        = '0;
        lookup_valid   = '0;
        lookup_use_rs1 = '0;
        lookup_use_rs2 = '0;
        lookup_rs1     = '0;
        lookup_rs2     = '0;
    endtask

    task automatic set_rename(int lane, int dst, int tag);
        rename_valid[lane] = 1'b1;
        rename_reg[lane]   = arch_reg_t'(dst);
        rename_tag[lane]   = rob_tag_t'(tag);
    endtask

    task automatic set_lookup(int lane, bit use1, int rs1, bit use2, int rs2);
        lookup_valid[lane]   = 1'b1;
        lookup_use_rs1[lane] = use1;
        lookup_use_rs2[lane] = use2;
        lookup_rs1[lane]     = arch_reg_t'(rs1);
        lookup_rs2[lane]     = arch_reg_t'(rs2);
    endtask

    task automatic model_reset();
        for (int k = 0; k < NUM_MAPPED_REGS; k++) begin
            ref_tab[k] = '0;
        end
    endtask

    // Previous state, then CDB ready, then renames in lane order, then clear
    task automatic model_update();
        logic [NUM_MAPPED_REGS-1:0] hit;
        int                         idx;
        for (int k = 0; k < NUM_MAPPED_REGS; k++) begin
            hit[k] = 1'b0;
            for (int l = 0; l < NUM_LANES; l++) begin
                if (cdb_valid[l] && ref_tab[k].mapped && (ref_tab[k].tag == cdb_tag[l])) begin
                    hit[k] = 1'b1;
                end
            end
        end
        if (!rst_n || squash) begin
            model_reset();
        end else begin
            for (int k = 0; k < NUM_MAPPED_REGS; k++) begin
                if (hit[k]) begin
                    ref_tab[k].ready = 1'b1;
                end
            end
            for (int l = 0; l < NUM_LANES; l++) begin
                if (rename_valid[l] && (rename_reg[l] != '0)) begin
                    idx = int'(rename_reg[l]) - 1;      // x1 lives in row 0
                    ref_tab[idx] = '{tag: rename_tag[l], ready: 1'b0, mapped: 1'b1};
                end
            end
        end
    endtask

    function automatic operand_map_t expect_src(logic valid, logic used, arch_reg_t src);
        operand_map_t res;
        int           idx;
        res = '0;
        idx = int'(src) - 1;
        if (valid && used && (src != '0)) begin
            if (ref_tab[idx].mapped) begin
                res = '{tag: ref_tab[idx].tag, ready: ref_tab[idx].ready, mapped: 1'b1};
            end
        end
        return res;
    endfunction

    task automatic check_field(string name, int lane, logic [7:0] exp_val, logic [7:0] act_val);
        check_count++;
        if (act_val !== exp_val) begin
            error_count++;
            $display("ERR %s[%0d] expected 0x%0h actual 0x%0h at %0t",
                     name, lane, exp_val, act_val, $time);
        end
    endtask

    task automatic expect_src1(int lane, int tag, bit ready, bit mapped);
        check_field("src1_tag", lane, 8'(tag), src1_tag[lane]);
        check_field("src1_ready", lane, 8'(ready), src1_ready[lane]);
        check_field("src1_mapped", lane, 8'(mapped), src1_mapped[lane]);
    endtask

    task automatic check_lookups();
        operand_map_t exp1;
        operand_map_t exp2;
        for (int l = 0; l < NUM_LANES; l++) begin
            exp1 = expect_src(lookup_valid[l], lookup_use_rs1[l], lookup_rs1[l]);
            exp2 = expect_src(lookup_valid[l], lookup_use_rs2[l], lookup_rs2[l]);
            check_field("src1_tag", l, exp1.tag, src1_tag[l]);
            check_field("src1_ready", l, exp1.ready, src1_ready[l]);
            check_field("src1_mapped", l, exp1.mapped, src1_mapped[l]);
            check_field("src2_tag", l, exp2.tag, src2_tag[l]);
            check_field("src2_ready", l, exp2.ready, src2_ready[l]);
            check_field("src2_mapped", l, exp2.mapped, src2_mapped[l]);
        end
    endtask

    // Entered at a falling edge with inputs driven, leaves at the next one
    task automatic run_cycle();
        #1;
        check_lookups();
        model_update();                         // Model of the state after the edge
        @(negedge clock);
    endtask

    task automatic test_reset_state();
        for (int c = 0; c < RESET_TEST_LEN; c++) begin
            clear_inputs();
            for (int l = 0; l < NUM_LANES; l++) begin
                set_lookup(l, 1'b1, 2 * c + 1, 1'b1, 2 * c + 2);   // Last pair wraps to x0
            end
            run_cycle();
        end
    endtask

    task automatic test_rename_lookup();
        clear_inputs();
        set_rename(0, 5, 3);
        set_rename(1, 10, 7);
        set_rename(2, 31, 20);
        set_lookup(0, 1'b1, 5, 1'b1, 0);        // rs2 is x0
        set_lookup(1, 1'b1, 10, 1'b0, 10);      // rs2 unused
        set_lookup(2, 1'b1, 31, 1'b1, 31);
        #1;
        expect_src1(2, 0, 1'b0, 1'b0);          // Not visible in the same cycle
        run_cycle();
        clear_inputs();
        set_lookup(0, 1'b1, 5, 1'b1, 0);
        set_lookup(1, 1'b1, 10, 1'b0, 10);
        set_lookup(2, 1'b1, 31, 1'b1, 31);
        #1;
        expect_src1(0, 3, 1'b0, 1'b1);
        expect_src1(1, 7, 1'b0, 1'b1);
        expect_src1(2, 20, 1'b0, 1'b1);
        run_cycle();
    endtask

    task automatic test_broadcast();
        clear_inputs();
        set_rename(0, 1, 4);
        set_rename(1, 2, 4);                    // Two rows share one tag
        set_rename(2, 3, 6);
        run_cycle();
        clear_inputs();
        cdb_valid[1] = 1'b1;
        cdb_tag[1]   = rob_tag_t'(4);
        for (int l = 0; l < NUM_LANES; l++) begin
            set_lookup(l, 1'b1, l + 1, 1'b1, 5);
        end
        #1;
        expect_src1(0, 4, 1'b0, 1'b1);
        run_cycle();
        clear_inputs();
        cdb_valid[0] = 1'b1;
        cdb_tag[0]   = rob_tag_t'(6);           // Old tag of x3
        set_rename(0, 3, 11);
        for (int l = 0; l < NUM_LANES; l++) begin
            set_lookup(l, 1'b1, l + 1, 1'b1, 5);
        end
        #1;
        expect_src1(0, 4, 1'b1, 1'b1);
        expect_src1(1, 4, 1'b1, 1'b1);
        expect_src1(2, 6, 1'b0, 1'b1);
        run_cycle();
        clear_inputs();
        set_lookup(2, 1'b1, 3, 1'b1, 1);
        #1;
        expect_src1(2, 11, 1'b0, 1'b1);         // New producer still pending
        run_cycle();
    endtask

    task automatic test_lane_priority();
        clear_inputs();
        set_rename(0, 7, 12);
        set_rename(1, 8, 13);
        set_rename(2, 7, 14);
        run_cycle();
        clear_inputs();
        set_lookup(0, 1'b1, 7, 1'b1, 8);
        #1;
        expect_src1(0, 14, 1'b0, 1'b1);
        run_cycle();
    endtask

    task automatic test_squash();
        clear_inputs();
        squash = 1'b1;
        set_rename(0, 9, 2);                    // Squash beats rename
        set_lookup(0, 1'b1, 1, 1'b1, 7);
        set_lookup(1, 1'b1, 5, 1'b1, 8);
        set_lookup(2, 1'b1, 10, 1'b1, 3);
        run_cycle();
        clear_inputs();
        set_lookup(0, 1'b1, 1, 1'b1, 7);
        set_lookup(1, 1'b1, 5, 1'b1, 8);
        set_lookup(2, 1'b1, 9, 1'b1, 31);
        #1;
        for (int l = 0; l < NUM_LANES; l++) begin
            expect_src1(l, 0, 1'b0, 1'b0);
        end
        run_cycle();
    endtask

    task automatic test_random();
        for (int c = 0; c < RANDOM_LEN; c++) begin
            clear_inputs();
            squash = (($urandom % 50) == 0);
            for (int l = 0; l < NUM_LANES; l++) begin
                rename_valid[l]   = 1'($urandom % 2);
                rename_reg[l]     = arch_reg_t'($urandom);
                rename_tag[l]     = rob_tag_t'($urandom);
                cdb_valid[l]      = 1'($urandom % 2);
                cdb_tag[l]        = ref_tab[$urandom % NUM_MAPPED_REGS].tag;  // Mostly live tags
                lookup_valid[l]   = (($urandom % 4) != 0);
                lookup_use_rs1[l] = 1'($urandom % 2);
                lookup_use_rs2[l] = 1'($urandom % 2);
                lookup_rs1[l]     = arch_reg_t'($urandom);
                lookup_rs2[l]     = arch_reg_t'($urandom);
            end
            run_cycle();
        end
    endtask

    initial begin
        #(WATCHDOG_TIME);
        $display("Timeout after %0d time units, tests did not complete", WATCHDOG_TIME);
        $display("Checks: %0d, errors: %0d", check_count, error_count);
        $display("Checks failed");
        $finish;
    end

    initial begin
        error_count = 0;
        check_count = 0;
        void'($urandom(80907));
        clear_inputs();
        rst_n = 1'b0;
        model_reset();
        repeat (RESET_CYCLES) @(negedge clock);
        rst_n = 1'b1;
        test_reset_state();
        test_rename_lookup();
        test_broadcast();
        test_lane_priority();
        test_squash();
        test_random();
        error_count += i_map_table.i_map_table_props.fail_count;   // Failed assertions
        $display("Checks: %0d, errors: %0d", check_count, error_count);
        if (error_count == 0) begin
            $display("All checks passed");
        end else begin
            $display("Checks failed");
        end
        $finish;
    end

endmodule
